// ==== logic/mci_pkg.sv ====
/*
  Shared definitions for the manageability block: bus and data widths,
  the Wishbone register map, hardware error bit positions and the packed
  struct types that carry signals between the blocks.
*/
`default_nettype none

package mci_pkg;

  localparam int DATA_W  = 32;
  localparam int ADDR_W  = 4;
  localparam int NUM_AGG = 8;

  //////////////////////////////
  // Register map (word addresses)
  //////////////////////////////
  localparam logic [ADDR_W-1:0] ADDR_WDT_CFG            = 4'h0;
  localparam logic [ADDR_W-1:0] ADDR_WDT_T1_PERIOD      = 4'h1;
  localparam logic [ADDR_W-1:0] ADDR_WDT_T2_PERIOD      = 4'h2;
  localparam logic [ADDR_W-1:0] ADDR_WDT_RESTART        = 4'h3;
  localparam logic [ADDR_W-1:0] ADDR_WDT_STATUS         = 4'h4;
  localparam logic [ADDR_W-1:0] ADDR_HW_ERR_FATAL       = 4'h5;
  localparam logic [ADDR_W-1:0] ADDR_HW_ERR_NON_FATAL   = 4'h6;
  localparam logic [ADDR_W-1:0] ADDR_FW_ERR_FATAL       = 4'h7;
  localparam logic [ADDR_W-1:0] ADDR_FW_ERR_NON_FATAL   = 4'h8;
  localparam logic [ADDR_W-1:0] ADDR_HW_FATAL_MASK      = 4'h9;
  localparam logic [ADDR_W-1:0] ADDR_HW_NON_FATAL_MASK  = 4'hA;
  localparam logic [ADDR_W-1:0] ADDR_AGG_FATAL_MASK     = 4'hB;
  localparam logic [ADDR_W-1:0] ADDR_AGG_NON_FATAL_MASK = 4'hC;

  // Hardware error bit positions
  localparam int HWF_NMI           = 0;
  localparam int HWF_SRAM_ECC_UNC  = 1;
  localparam int HWF_DMI_COLLISION = 2;
  localparam int HWF_W             = 3;

  localparam int HWN_MBOX0_ECC_UNC = 0;
  localparam int HWN_MBOX1_ECC_UNC = 1;
  localparam int HWN_W             = 2;

  //////////////////////////////
  // Bus types
  //////////////////////////////
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  //////////////////////////////
  // Watchdog types
  //////////////////////////////
  typedef struct packed {
    logic              timer1_en;
    logic              timer2_en;
    logic [DATA_W-1:0] t1_period;
    logic [DATA_W-1:0] t2_period;
  } wdt_cfg_t;

  // Single-cycle strobes decoded from bus writes
  typedef struct packed {
    logic restart1;
    logic restart2;
    logic service1;
    logic service2;
  } wdt_ctl_t;

  typedef struct packed {
    logic t1_timeout;
    logic t2_timeout;
  } wdt_status_t;

  //////////////////////////////
  // Error types
  //////////////////////////////
  typedef struct packed {
    logic              hw_fatal_clr;
    logic              hw_non_fatal_clr;
    logic              fw_fatal_we;
    logic              fw_non_fatal_we;
    logic [DATA_W-1:0] wdata;
  } err_csr_t;

  typedef struct packed {
    logic [HWF_W-1:0]   hw_fatal;
    logic [HWN_W-1:0]   hw_non_fatal;
    logic [NUM_AGG-1:0] agg_fatal;
    logic [NUM_AGG-1:0] agg_non_fatal;
  } err_mask_t;

  typedef struct packed {
    logic [HWF_W-1:0]  hw_fatal;
    logic [HWN_W-1:0]  hw_non_fatal;
    logic [DATA_W-1:0] fw_fatal;
    logic [DATA_W-1:0] fw_non_fatal;
  } err_regs_t;

  typedef struct packed {
    logic sram_ecc_unc;
    logic dmi_collision;
    logic mbox0_ecc_unc;
    logic mbox1_ecc_unc;
  } hw_err_in_t;

  typedef struct packed {
    logic all_error_fatal;
    logic all_error_non_fatal;
  } err_out_t;

endpackage

`default_nettype wire

// ==== logic/mci_wb_regs.sv ====
/*
  Wishbone classic slave with single-cycle ack and address decode.
  Holds the watchdog configuration and the four mask registers, turns
  writes into one-cycle control strobes and muxes the readback word.
*/
`timescale 1ns/1ps
`default_nettype none

module mci_wb_regs (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  input  wire mci_pkg::wb_req_t     wb_req_i,
  output mci_pkg::wb_rsp_t          wb_rsp_o,
  input  wire mci_pkg::wdt_status_t wdt_status_i,
  input  wire mci_pkg::err_regs_t   err_regs_i,
  output mci_pkg::wdt_cfg_t         wdt_cfg_o,
  output mci_pkg::wdt_ctl_t         wdt_ctl_o,
  output mci_pkg::err_csr_t         err_csr_o,
  output mci_pkg::err_mask_t        err_mask_o
);

  logic                        ack_q;
  logic                        accept;
  logic                        wr_en;
  logic [mci_pkg::DATA_W-1:0]  rdata_d;
  logic [mci_pkg::DATA_W-1:0]  rdata_q;
  mci_pkg::wdt_cfg_t           cfg_q;
  mci_pkg::err_mask_t          mask_q;

  //////////////////////////////
  // Bus handshake
  //////////////////////////////

  // A new cycle is only taken when ack is low, so back-to-back strobes
  // are answered every second clock
  assign accept = wb_req_i.cyc && wb_req_i.stb && !ack_q;
  assign wr_en  = accept && wb_req_i.we;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  // Read data is captured with the access and presented alongside ack
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = ack_q ? rdata_q : '0;

  //////////////////////////////
  // Local registers
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q  <= '0;
      mask_q <= '0;
    end else if (wr_en) begin
      case (wb_req_i.adr)
        mci_pkg::ADDR_WDT_CFG: begin
          cfg_q.timer1_en <= wb_req_i.dat[0];
          cfg_q.timer2_en <= wb_req_i.dat[1];
        end
        mci_pkg::ADDR_WDT_T1_PERIOD:      cfg_q.t1_period <= wb_req_i.dat;
        mci_pkg::ADDR_WDT_T2_PERIOD:      cfg_q.t2_period <= wb_req_i.dat;
        mci_pkg::ADDR_HW_FATAL_MASK:
          mask_q.hw_fatal <= wb_req_i.dat[mci_pkg::HWF_W-1:0];
        mci_pkg::ADDR_HW_NON_FATAL_MASK:
          mask_q.hw_non_fatal <= wb_req_i.dat[mci_pkg::HWN_W-1:0];
        mci_pkg::ADDR_AGG_FATAL_MASK:
          mask_q.agg_fatal <= wb_req_i.dat[mci_pkg::NUM_AGG-1:0];
        mci_pkg::ADDR_AGG_NON_FATAL_MASK:
          mask_q.agg_non_fatal <= wb_req_i.dat[mci_pkg::NUM_AGG-1:0];
        default: ;
      endcase
    end
  end

  assign wdt_cfg_o  = cfg_q;
  assign err_mask_o = mask_q;

  //////////////////////////////
  // Write strobes
  //////////////////////////////

  // These act on the same edge that raises ack
  always_comb begin
    wdt_ctl_o.restart1 = wr_en && (wb_req_i.adr == mci_pkg::ADDR_WDT_RESTART) && wb_req_i.dat[0];
    wdt_ctl_o.restart2 = wr_en && (wb_req_i.adr == mci_pkg::ADDR_WDT_RESTART) && wb_req_i.dat[1];
    wdt_ctl_o.service1 = wr_en && (wb_req_i.adr == mci_pkg::ADDR_WDT_STATUS) && wb_req_i.dat[0];
    wdt_ctl_o.service2 = wr_en && (wb_req_i.adr == mci_pkg::ADDR_WDT_STATUS) && wb_req_i.dat[1];

    err_csr_o.hw_fatal_clr     = wr_en && (wb_req_i.adr == mci_pkg::ADDR_HW_ERR_FATAL);
    err_csr_o.hw_non_fatal_clr = wr_en && (wb_req_i.adr == mci_pkg::ADDR_HW_ERR_NON_FATAL);
    err_csr_o.fw_fatal_we      = wr_en && (wb_req_i.adr == mci_pkg::ADDR_FW_ERR_FATAL);
    err_csr_o.fw_non_fatal_we  = wr_en && (wb_req_i.adr == mci_pkg::ADDR_FW_ERR_NON_FATAL);
    err_csr_o.wdata            = wb_req_i.dat;
  end

  //////////////////////////////
  // Readback mux
  //////////////////////////////
  always_comb begin
    rdata_d = '0;
    case (wb_req_i.adr)
      mci_pkg::ADDR_WDT_CFG:       rdata_d[1:0] = {cfg_q.timer2_en, cfg_q.timer1_en};
      mci_pkg::ADDR_WDT_T1_PERIOD: rdata_d = cfg_q.t1_period;
      mci_pkg::ADDR_WDT_T2_PERIOD: rdata_d = cfg_q.t2_period;
      mci_pkg::ADDR_WDT_STATUS:
        rdata_d[1:0] = {wdt_status_i.t2_timeout, wdt_status_i.t1_timeout};
      mci_pkg::ADDR_HW_ERR_FATAL:
        rdata_d[mci_pkg::HWF_W-1:0] = err_regs_i.hw_fatal;
      mci_pkg::ADDR_HW_ERR_NON_FATAL:
        rdata_d[mci_pkg::HWN_W-1:0] = err_regs_i.hw_non_fatal;
      mci_pkg::ADDR_FW_ERR_FATAL:     rdata_d = err_regs_i.fw_fatal;
      mci_pkg::ADDR_FW_ERR_NON_FATAL: rdata_d = err_regs_i.fw_non_fatal;
      mci_pkg::ADDR_HW_FATAL_MASK:
        rdata_d[mci_pkg::HWF_W-1:0] = mask_q.hw_fatal;
      mci_pkg::ADDR_HW_NON_FATAL_MASK:
        rdata_d[mci_pkg::HWN_W-1:0] = mask_q.hw_non_fatal;
      mci_pkg::ADDR_AGG_FATAL_MASK:
        rdata_d[mci_pkg::NUM_AGG-1:0] = mask_q.agg_fatal;
      mci_pkg::ADDR_AGG_NON_FATAL_MASK:
        rdata_d[mci_pkg::NUM_AGG-1:0] = mask_q.agg_non_fatal;
      default: rdata_d = '0;
    endcase
  end

  // Every ack answers a request that was on the bus one clock earlier
  ack_follows_req: assert property (
    @(posedge clk_i) disable iff (reset_i)
    wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb)
  ) else $error("ack raised without a preceding request");

endmodule

`default_nettype wire

// ==== logic/mci_wdt.sv ====
/*
  Two-timer watchdog. Timer 2 runs on its own when enabled, or in
  cascade behind timer 1 when only timer 1 is enabled. Each timer has
  a restart strobe and a service strobe that also clears its flag.
*/
`timescale 1ns/1ps
`default_nettype none

module mci_wdt (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  input  wire mci_pkg::wdt_cfg_t    wdt_cfg_i,
  input  wire mci_pkg::wdt_ctl_t    wdt_ctl_i,
  output mci_pkg::wdt_status_t      wdt_status_o
);

  logic [mci_pkg::DATA_W-1:0] t1_count;
  logic [mci_pkg::DATA_W-1:0] t2_count;
  logic                       t1_timeout;
  logic                       t2_timeout;
  logic                       t1_run;
  logic                       t2_run;
  logic                       cascade;

  assign cascade = wdt_cfg_i.timer1_en && !wdt_cfg_i.timer2_en;

  // A timer stops counting once its flag is set
  assign t1_run = wdt_cfg_i.timer1_en && !t1_timeout;
  assign t2_run = !t2_timeout && (wdt_cfg_i.timer2_en || (cascade && t1_timeout));

  //////////////////////////////
  // Timer 1
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      t1_count   <= '0;
      t1_timeout <= 1'b0;
    end else if (wdt_ctl_i.service1) begin
      t1_count   <= '0;
      t1_timeout <= 1'b0;
    end else if (wdt_ctl_i.restart1 && !t1_timeout) begin
      t1_count <= '0;
    end else if (t1_run) begin
      if (t1_count == wdt_cfg_i.t1_period) begin
        t1_timeout <= 1'b1;
      end else begin
        t1_count <= t1_count + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Timer 2
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      t2_count   <= '0;
      t2_timeout <= 1'b0;
    end else if (wdt_ctl_i.service2) begin
      t2_count   <= '0;
      t2_timeout <= 1'b0;
    end else if (wdt_ctl_i.restart2 && !t2_timeout) begin
      t2_count <= '0;
    end else if (t2_run) begin
      if (t2_count == wdt_cfg_i.t2_period) begin
        t2_timeout <= 1'b1;
      end else begin
        t2_count <= t2_count + 1'b1;
      end
    end
  end

  assign wdt_status_o.t1_timeout = t1_timeout;
  assign wdt_status_o.t2_timeout = t2_timeout;

  //////////////////////////////
  // Checks
  //////////////////////////////

  // A pet on a live timer zeroes its count on the following edge
  t1_pet_restarts: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (wdt_ctl_i.restart1 && wdt_cfg_i.timer1_en && !t1_timeout) |=> (t1_count == '0)
  ) else $error("timer 1 did not restart on pet");

  t2_pet_restarts: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (wdt_ctl_i.restart2 && !t2_timeout) |=> (t2_count == '0)
  ) else $error("timer 2 did not restart on pet");

  // Timer 1 can only expire if it was enabled while it counted
  t1_expiry_needs_enable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $rose(t1_timeout) |-> $past(wdt_cfg_i.timer1_en)
  ) else $error("timer 1 expired while disabled");

endmodule

`default_nettype wire

// ==== logic/mci_error_agg.sv ====
/*
  Error collection: sticky hardware error bits with write-one-to-clear,
  firmware error codes, and the registered masked summary outputs.
*/
`timescale 1ns/1ps
`default_nettype none

module mci_error_agg (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,
  input  wire mci_pkg::err_csr_t           err_csr_i,
  input  wire mci_pkg::err_mask_t          err_mask_i,
  input  wire mci_pkg::hw_err_in_t         hw_err_i,
  input  wire logic                        nmi_i,
  input  wire logic [mci_pkg::NUM_AGG-1:0] agg_fatal_i,
  input  wire logic [mci_pkg::NUM_AGG-1:0] agg_non_fatal_i,
  output mci_pkg::err_regs_t               err_regs_o,
  output mci_pkg::err_out_t                err_o
);

  logic                       nmi_q;
  logic [mci_pkg::HWF_W-1:0]  hwf_set;
  logic [mci_pkg::HWN_W-1:0]  hwn_set;
  logic [mci_pkg::HWF_W-1:0]  hwf_clr;
  logic [mci_pkg::HWN_W-1:0]  hwn_clr;
  mci_pkg::err_regs_t         regs_q;
  mci_pkg::err_out_t          out_q;

  // Only the rising edge of the timer 2 timeout counts as an NMI event
  always_comb begin
    hwf_set = '0;
    hwf_set[mci_pkg::HWF_NMI]           = nmi_i && !nmi_q;
    hwf_set[mci_pkg::HWF_SRAM_ECC_UNC]  = hw_err_i.sram_ecc_unc;
    hwf_set[mci_pkg::HWF_DMI_COLLISION] = hw_err_i.dmi_collision;
    hwn_set = '0;
    hwn_set[mci_pkg::HWN_MBOX0_ECC_UNC] = hw_err_i.mbox0_ecc_unc;
    hwn_set[mci_pkg::HWN_MBOX1_ECC_UNC] = hw_err_i.mbox1_ecc_unc;
  end

  assign hwf_clr = err_csr_i.hw_fatal_clr ? err_csr_i.wdata[mci_pkg::HWF_W-1:0] : '0;
  assign hwn_clr = err_csr_i.hw_non_fatal_clr ? err_csr_i.wdata[mci_pkg::HWN_W-1:0] : '0;

  //////////////////////////////
  // Error registers
  //////////////////////////////

  // A set in the same cycle as a clear wins
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      nmi_q  <= 1'b0;
      regs_q <= '0;
    end else begin
      nmi_q               <= nmi_i;
      regs_q.hw_fatal     <= (regs_q.hw_fatal & ~hwf_clr) | hwf_set;
      regs_q.hw_non_fatal <= (regs_q.hw_non_fatal & ~hwn_clr) | hwn_set;
      if (err_csr_i.fw_fatal_we) begin
        regs_q.fw_fatal <= err_csr_i.wdata;
      end
      if (err_csr_i.fw_non_fatal_we) begin
        regs_q.fw_non_fatal <= err_csr_i.wdata;
      end
    end
  end

  assign err_regs_o = regs_q;

  //////////////////////////////
  // Summary outputs
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q <= '0;
    end else begin
      out_q.all_error_fatal <= (|(regs_q.hw_fatal & ~err_mask_i.hw_fatal)) ||
                               (|regs_q.fw_fatal) ||
                               (|(agg_fatal_i & ~err_mask_i.agg_fatal));
      out_q.all_error_non_fatal <= (|(regs_q.hw_non_fatal & ~err_mask_i.hw_non_fatal)) ||
                                   (|regs_q.fw_non_fatal) ||
                                   (|(agg_non_fatal_i & ~err_mask_i.agg_non_fatal));
    end
  end

  assign err_o = out_q;

  // Every hardware error event leaves its sticky bit set one edge later
  hw_err_sticky_set: assert property (
    @(posedge clk_i) disable iff (reset_i)
    ({hwf_set, hwn_set} != '0) |=>
      (({regs_q.hw_fatal, regs_q.hw_non_fatal} & $past({hwf_set, hwn_set})) ==
       $past({hwf_set, hwn_set}))
  ) else $error("hardware error pulse did not set its sticky bit");

endmodule

`default_nettype wire

// ==== logic/mci_top.sv ====
/*
  Top level of the manageability block. Connects the Wishbone register
  block, the watchdog and the error collection logic.
*/
`timescale 1ns/1ps
`default_nettype none

module mci_top (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,
  input  wire mci_pkg::wb_req_t            wb_req_i,
  output mci_pkg::wb_rsp_t                 wb_rsp_o,
  input  wire mci_pkg::hw_err_in_t         hw_err_i,
  input  wire logic [mci_pkg::NUM_AGG-1:0] agg_fatal_i,
  input  wire logic [mci_pkg::NUM_AGG-1:0] agg_non_fatal_i,
  output mci_pkg::err_out_t                err_o
);

  mci_pkg::wdt_cfg_t    wdt_cfg;
  mci_pkg::wdt_ctl_t    wdt_ctl;
  mci_pkg::wdt_status_t wdt_status;
  mci_pkg::err_csr_t    err_csr;
  mci_pkg::err_mask_t   err_mask;
  mci_pkg::err_regs_t   err_regs;

  mci_wb_regs u_wb_regs (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .wb_req_i     (wb_req_i),
    .wb_rsp_o     (wb_rsp_o),
    .wdt_status_i (wdt_status),
    .err_regs_i   (err_regs),
    .wdt_cfg_o    (wdt_cfg),
    .wdt_ctl_o    (wdt_ctl),
    .err_csr_o    (err_csr),
    .err_mask_o   (err_mask)
  );

  mci_wdt u_wdt (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .wdt_cfg_i    (wdt_cfg),
    .wdt_ctl_i    (wdt_ctl),
    .wdt_status_o (wdt_status)
  );

  // Timer 2 expiry is the NMI source for the fatal error register
  mci_error_agg u_error_agg (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .err_csr_i       (err_csr),
    .err_mask_i      (err_mask),
    .hw_err_i        (hw_err_i),
    .nmi_i           (wdt_status.t2_timeout),
    .agg_fatal_i     (agg_fatal_i),
    .agg_non_fatal_i (agg_non_fatal_i),
    .err_regs_o      (err_regs),
    .err_o           (err_o)
  );

endmodule

`default_nettype wire

// ==== sim/mci_tb_checks.svh ====
/*
  Bus access task for the Wishbone classic slave and the compare tasks
  for read words and the summary error outputs. Included inside the
  testbench module, so it sees the testbench signals and counters.
*/
`ifndef MCI_TB_CHECKS_SVH
`define MCI_TB_CHECKS_SVH

// One complete Wishbone cycle. Starts on a falling edge and returns on
// the falling edge where ack was seen, with the bus request dropped
task automatic bus_access(input logic we, input logic [mci_pkg::ADDR_W-1:0] adr,
                          input logic [mci_pkg::DATA_W-1:0] wdata,
                          output logic [mci_pkg::DATA_W-1:0] rdata);
  int waited;
  waited = 1;
  wb_req.cyc = 1'b1;
  wb_req.stb = 1'b1;
  wb_req.we  = we;
  wb_req.adr = adr;
  wb_req.dat = wdata;
  @(negedge clk);
  // Eight cycles is far more than the slave ever needs
  while (!wb_rsp.ack && waited < 8) begin
    @(negedge clk);
    waited++;
  end
  rdata = wb_rsp.dat;
  if (!wb_rsp.ack) begin
    $display("No ack from the bus slave for address %h within %0d cycles", adr, waited);
    fail_count++;
  end
  wb_req = '0;
endtask

task automatic check_word(input logic [mci_pkg::DATA_W-1:0] got,
                          input logic [mci_pkg::DATA_W-1:0] exp,
                          input string what);
  if (got !== exp) begin
    $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
    mismatch_count++;
  end
endtask

task automatic check_err(input mci_pkg::err_out_t got, input mci_pkg::err_out_t exp,
                         input string what);
  if (got !== exp) begin
    $display("MISMATCH at %0t: %s fatal=%b non_fatal=%b, expected fatal=%b non_fatal=%b",
             $time, what, got.all_error_fatal, got.all_error_non_fatal,
             exp.all_error_fatal, exp.all_error_non_fatal);
    mismatch_count++;
  end
endtask

`endif

// ==== sim/mci_tb.sv ====
/*
  Testbench for the manageability block: clock, reset, a stimulus table
  covering registers, watchdog cascade and restart, hardware, aggregated
  and firmware errors, the loop that applies it, and the run limit.
*/
`timescale 1ns/1ps
`default_nettype none

module mci_tb;

  typedef enum int {OP_WRITE, OP_READ, OP_LINES, OP_WAIT, OP_POLL, OP_ERR} op_t;

  // Data is write data, read expectation or poll value depending on op
  typedef struct {
    op_t                        op;
    logic [mci_pkg::ADDR_W-1:0]  adr;
    logic [mci_pkg::DATA_W-1:0]  data;
    logic [mci_pkg::DATA_W-1:0]  mask;
    int                         cycles;
    mci_pkg::hw_err_in_t        hw;
    logic [mci_pkg::NUM_AGG-1:0] agf;
    logic [mci_pkg::NUM_AGG-1:0] agn;
    mci_pkg::err_out_t          err;
    string                      note;
  } entry_t;

  logic                        clk = 1'b0;
  logic                        reset;
  mci_pkg::wb_req_t            wb_req;
  mci_pkg::wb_rsp_t            wb_rsp;
  mci_pkg::hw_err_in_t         hw_err;
  logic [mci_pkg::NUM_AGG-1:0] agg_fatal;
  logic [mci_pkg::NUM_AGG-1:0] agg_non_fatal;
  mci_pkg::err_out_t           err_out;

  entry_t steps[$];
  integer seed;
  int     mismatch_count = 0;
  int     fail_count = 0;
  int     cycle_count = 0;
  int     cycle_limit = 0;

  mci_top dut (
    .clk_i           (clk),
    .reset_i         (reset),
    .wb_req_i        (wb_req),
    .wb_rsp_o        (wb_rsp),
    .hw_err_i        (hw_err),
    .agg_fatal_i     (agg_fatal),
    .agg_non_fatal_i (agg_non_fatal),
    .err_o           (err_out)
  );

  `include "mci_tb_checks.svh"

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Run stopped after %0d cycles, the test did not finish in time", cycle_count);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////
  // Table entries
  //////////////////////////////
  function automatic void push_step(op_t op, logic [mci_pkg::ADDR_W-1:0] adr,
                                    logic [mci_pkg::DATA_W-1:0] data,
                                    logic [mci_pkg::DATA_W-1:0] mask, int cycles, string note);
    entry_t e;
    e.op     = op;
    e.adr    = adr;
    e.data   = data;
    e.mask   = mask;
    e.cycles = cycles;
    e.hw     = '0;
    e.agf    = '0;
    e.agn    = '0;
    e.err    = '0;
    e.note   = note;
    steps.push_back(e);
  endfunction

  function automatic void write_step(logic [3:0] adr, logic [31:0] data);
    push_step(OP_WRITE, adr, data, '0, 0, "write");
  endfunction

  function automatic void read_step(logic [3:0] adr, logic [31:0] exp, string note);
    push_step(OP_READ, adr, exp, '0, 0, note);
  endfunction

  function automatic void wait_step(int n);
    push_step(OP_WAIT, '0, '0, '0, n, "wait");
  endfunction

  function automatic void poll_step(logic [3:0] adr, logic [31:0] mask, logic [31:0] value,
                                    int limit, string note);
    push_step(OP_POLL, adr, value, mask, limit, note);
  endfunction

  function automatic void lines_step(logic sram, logic dmi, logic mbox0, logic mbox1,
                                     logic [7:0] agf, logic [7:0] agn);
    entry_t e;
    push_step(OP_LINES, '0, '0, '0, 0, "lines");
    e = steps.pop_back();
    e.hw.sram_ecc_unc  = sram;
    e.hw.dmi_collision = dmi;
    e.hw.mbox0_ecc_unc = mbox0;
    e.hw.mbox1_ecc_unc = mbox1;
    e.agf = agf;
    e.agn = agn;
    steps.push_back(e);
  endfunction

  function automatic void err_step(logic fatal, logic non_fatal, string note);
    entry_t e;
    push_step(OP_ERR, '0, '0, '0, 0, note);
    e = steps.pop_back();
    e.err.all_error_fatal     = fatal;
    e.err.all_error_non_fatal = non_fatal;
    steps.push_back(e);
  endfunction

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  task automatic build_table();
    logic [31:0] p1;
    logic [31:0] p2;
    logic [31:0] p3;
    logic [31:0] code;
    logic [7:0]  af;
    logic [7:0]  an;
    logic [7:0]  mf;
    logic [7:0]  mn;
    p1 = 32'd20 + {$random(seed)} % 32'd41;
    p2 = 32'd20 + {$random(seed)} % 32'd41;
    p3 = 32'd20 + {$random(seed)} % 32'd41;
    mf = 8'($random(seed));
    mn = 8'($random(seed));

    // Reset values, an unmapped address, then register round trips
    for (int a = 0; a <= int'(mci_pkg::ADDR_AGG_NON_FATAL_MASK); a++) begin
      read_step(4'(a), '0, "reset value");
    end
    write_step(4'hF, 32'hFFFF_FFFF);
    read_step(4'hF, '0, "unmapped address");
    err_step(1'b0, 1'b0, "summary after reset");
    write_step(mci_pkg::ADDR_WDT_T1_PERIOD, p1);
    write_step(mci_pkg::ADDR_WDT_T2_PERIOD, p2);
    write_step(mci_pkg::ADDR_HW_FATAL_MASK, 32'h5);
    write_step(mci_pkg::ADDR_HW_NON_FATAL_MASK, 32'h2);
    write_step(mci_pkg::ADDR_AGG_FATAL_MASK, 32'(mf));
    write_step(mci_pkg::ADDR_AGG_NON_FATAL_MASK, 32'(mn));
    read_step(mci_pkg::ADDR_WDT_T1_PERIOD, p1, "t1 period");
    read_step(mci_pkg::ADDR_WDT_T2_PERIOD, p2, "t2 period");
    read_step(mci_pkg::ADDR_HW_FATAL_MASK, 32'h5, "hw fatal mask");
    read_step(mci_pkg::ADDR_HW_NON_FATAL_MASK, 32'h2, "hw non-fatal mask");
    read_step(mci_pkg::ADDR_AGG_FATAL_MASK, 32'(mf), "agg fatal mask");
    read_step(mci_pkg::ADDR_AGG_NON_FATAL_MASK, 32'(mn), "agg non-fatal mask");
    write_step(mci_pkg::ADDR_HW_FATAL_MASK, '0);
    write_step(mci_pkg::ADDR_HW_NON_FATAL_MASK, '0);

    // In cascade mode timer 2 only runs once timer 1 has expired
    write_step(mci_pkg::ADDR_WDT_CFG, 32'h1);
    poll_step(mci_pkg::ADDR_WDT_STATUS, 32'h3, 32'h1, 200, "t1 timeout ahead of t2");
    poll_step(mci_pkg::ADDR_WDT_STATUS, 32'h3, 32'h3, 200, "t2 timeout");
    wait_step(3);
    read_step(mci_pkg::ADDR_HW_ERR_FATAL, 32'd1 << mci_pkg::HWF_NMI, "nmi sticky bit");
    err_step(1'b1, 1'b0, "summary after nmi");
    write_step(mci_pkg::ADDR_WDT_CFG, '0);
    write_step(mci_pkg::ADDR_WDT_STATUS, 32'h3);
    read_step(mci_pkg::ADDR_WDT_STATUS, '0, "status after service");
    write_step(mci_pkg::ADDR_HW_ERR_FATAL, 32'd1 << mci_pkg::HWF_NMI);
    read_step(mci_pkg::ADDR_HW_ERR_FATAL, '0, "nmi bit after clear");
    wait_step(3);
    err_step(1'b0, 1'b0, "summary after nmi clear");

    // Regular pets keep timer 1 from expiring
    write_step(mci_pkg::ADDR_WDT_T1_PERIOD, p3);
    write_step(mci_pkg::ADDR_WDT_CFG, 32'h1);
    for (int k = 0; k < 6; k++) begin
      write_step(mci_pkg::ADDR_WDT_RESTART, 32'h1);
      wait_step(7);
      read_step(mci_pkg::ADDR_WDT_STATUS, '0, "status while petted");
    end
    poll_step(mci_pkg::ADDR_WDT_STATUS, 32'h1, 32'h1, 200, "t1 timeout after pets stop");
    write_step(mci_pkg::ADDR_WDT_CFG, '0);
    write_step(mci_pkg::ADDR_WDT_STATUS, 32'h3);
    read_step(mci_pkg::ADDR_WDT_STATUS, '0, "status after second service");

    // Sticky hardware bits, write-one-to-clear and masking
    lines_step(1'b1, 1'b0, 1'b0, 1'b1, '0, '0);
    wait_step(1);
    lines_step(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
    wait_step(3);
    read_step(mci_pkg::ADDR_HW_ERR_FATAL, 32'd1 << mci_pkg::HWF_SRAM_ECC_UNC, "sram ecc bit");
    read_step(mci_pkg::ADDR_HW_ERR_NON_FATAL, 32'd1 << mci_pkg::HWN_MBOX1_ECC_UNC, "mbox1 bit");
    err_step(1'b1, 1'b1, "summary after hw pulses");
    lines_step(1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
    wait_step(1);
    lines_step(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
    wait_step(3);
    read_step(mci_pkg::ADDR_HW_ERR_FATAL, (32'd1 << mci_pkg::HWF_SRAM_ECC_UNC) |
              (32'd1 << mci_pkg::HWF_DMI_COLLISION), "fatal bits accumulate");
    read_step(mci_pkg::ADDR_HW_ERR_NON_FATAL, (32'd1 << mci_pkg::HWN_MBOX0_ECC_UNC) |
              (32'd1 << mci_pkg::HWN_MBOX1_ECC_UNC), "non-fatal bits accumulate");
    write_step(mci_pkg::ADDR_HW_ERR_FATAL, 32'd1 << mci_pkg::HWF_SRAM_ECC_UNC);
    read_step(mci_pkg::ADDR_HW_ERR_FATAL, 32'd1 << mci_pkg::HWF_DMI_COLLISION, "fatal w1c");
    write_step(mci_pkg::ADDR_HW_ERR_NON_FATAL, 32'd1 << mci_pkg::HWN_MBOX0_ECC_UNC);
    read_step(mci_pkg::ADDR_HW_ERR_NON_FATAL, 32'd1 << mci_pkg::HWN_MBOX1_ECC_UNC,
              "non-fatal w1c");
    write_step(mci_pkg::ADDR_HW_FATAL_MASK, 32'd1 << mci_pkg::HWF_DMI_COLLISION);
    write_step(mci_pkg::ADDR_HW_NON_FATAL_MASK, 32'd1 << mci_pkg::HWN_MBOX1_ECC_UNC);
    wait_step(3);
    read_step(mci_pkg::ADDR_HW_ERR_FATAL, 32'd1 << mci_pkg::HWF_DMI_COLLISION, "masked bit");
    read_step(mci_pkg::ADDR_HW_ERR_NON_FATAL, 32'd1 << mci_pkg::HWN_MBOX1_ECC_UNC,
              "masked non-fatal bit");
    err_step(1'b0, 1'b0, "summary with hw masks");
    write_step(mci_pkg::ADDR_HW_ERR_FATAL, 32'h7);
    write_step(mci_pkg::ADDR_HW_ERR_NON_FATAL, 32'h3);
    write_step(mci_pkg::ADDR_HW_FATAL_MASK, '0);
    write_step(mci_pkg::ADDR_HW_NON_FATAL_MASK, '0);

    // Aggregated lines against random masks
    for (int k = 0; k < 4; k++) begin
      af = 8'($random(seed));
      an = 8'($random(seed));
      mf = 8'($random(seed));
      mn = 8'($random(seed));
      write_step(mci_pkg::ADDR_AGG_FATAL_MASK, 32'(mf));
      write_step(mci_pkg::ADDR_AGG_NON_FATAL_MASK, 32'(mn));
      lines_step(1'b0, 1'b0, 1'b0, 1'b0, af, an);
      wait_step(3);
      err_step(|(af & ~mf), |(an & ~mn), "aggregated summary");
    end
    lines_step(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
    write_step(mci_pkg::ADDR_AGG_FATAL_MASK, '0);
    write_step(mci_pkg::ADDR_AGG_NON_FATAL_MASK, '0);
    wait_step(3);
    err_step(1'b0, 1'b0, "summary with lines idle");

    // Firmware codes
    code = {$random(seed)} | 32'h1;
    write_step(mci_pkg::ADDR_FW_ERR_FATAL, code);
    wait_step(3);
    err_step(1'b1, 1'b0, "summary with fw fatal code");
    read_step(mci_pkg::ADDR_FW_ERR_FATAL, code, "fw fatal code");
    write_step(mci_pkg::ADDR_FW_ERR_FATAL, '0);
    wait_step(3);
    err_step(1'b0, 1'b0, "summary after fw fatal cleared");
    code = {$random(seed)} | 32'h1;
    write_step(mci_pkg::ADDR_FW_ERR_NON_FATAL, code);
    wait_step(3);
    err_step(1'b0, 1'b1, "summary with fw non-fatal code");
    read_step(mci_pkg::ADDR_FW_ERR_NON_FATAL, code, "fw non-fatal code");
    write_step(mci_pkg::ADDR_FW_ERR_NON_FATAL, '0);
    wait_step(3);
    err_step(1'b0, 1'b0, "summary after fw non-fatal cleared");
  endtask

  //////////////////////////////
  // Apply the table
  //////////////////////////////
  initial begin
    logic [mci_pkg::DATA_W-1:0] rd;
    int                         start;
    bit                         hit;
    seed          = 32'h42aaa65a;
    reset         = 1'b1;
    wb_req        = '0;
    hw_err        = '0;
    agg_fatal     = '0;
    agg_non_fatal = '0;
    build_table();
    // Waits and poll limits set the budget and the margin covers bus cycles
    foreach (steps[i]) begin
      if (steps[i].op == OP_WAIT || steps[i].op == OP_POLL) begin
        cycle_limit += steps[i].cycles;
      end
    end
    cycle_limit += 200;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    foreach (steps[i]) begin
      case (steps[i].op)
        OP_WRITE: bus_access(1'b1, steps[i].adr, steps[i].data, rd);
        OP_READ: begin
          bus_access(1'b0, steps[i].adr, '0, rd);
          check_word(rd, steps[i].data, steps[i].note);
        end
        OP_LINES: begin
          hw_err        = steps[i].hw;
          agg_fatal     = steps[i].agf;
          agg_non_fatal = steps[i].agn;
        end
        OP_WAIT: repeat (steps[i].cycles) @(negedge clk);
        OP_POLL: begin
          start = cycle_count;
          hit   = 1'b0;
          while (!hit && (cycle_count - start) < steps[i].cycles) begin
            bus_access(1'b0, steps[i].adr, '0, rd);
            hit = ((rd & steps[i].mask) == steps[i].data);
          end
          if (!hit) begin
            $display("Poll for %s gave up after %0d cycles", steps[i].note, steps[i].cycles);
            fail_count++;
          end
        end
        OP_ERR: check_err(err_out, steps[i].err, steps[i].note);
        default: ;
      endcase
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+sim
logic/mci_pkg.sv
logic/mci_wb_regs.sv
logic/mci_wdt.sv
logic/mci_error_agg.sv
logic/mci_top.sv
sim/mci_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module mci_tb -o mci_tb \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/mci_tb > sim.log 2>&1
cat sim.log
grep -qx "Test passed" sim.log && echo "Simulation PASS" \
  || { echo "Simulation FAIL, see sim.log"; exit 1; }
